//--- source/sbuf_pkg.sv
/* Bus widths and the store size encoding used by the store unit.
   Imported by every RTL block and by the testbench. */
package sbuf_pkg;

  localparam int XLEN   = 32;       // Address, data and pc width.
  localparam int STRB_W = XLEN / 8; // One strobe per byte lane.

  // Access size issued by the pipeline.
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0, // Single byte.
    SIZE_HALF = 2'd1, // Halfword, must be 2-byte aligned.
    SIZE_WORD = 2'd2  // Full word, must be 4-byte aligned.
  } store_size_e;

endpackage

//--- source/store_entry_if.sv
/* One buffered store with a valid/ready handshake between store path blocks.
   The producer takes src, the consumer takes dst. */
`timescale 1ns/10ps

interface store_entry_if
  import sbuf_pkg::*;
();

  logic [XLEN-1:0]   adr;   // Word address, bits 1:0 are zero.
  logic [XLEN-1:0]   dat;   // Data already replicated across lanes.
  logic [STRB_W-1:0] bsel;  // Byte strobes.
  logic [XLEN-1:0]   pc;    // Pc of the store, kept for error reports.
  logic              valid; // Entry offered.
  logic              ready; // Entry taken.

  // Fields stay stable while valid is high and ready is low.
  modport src (output adr, dat, bsel, pc, valid, input ready);
  modport dst (input adr, dat, bsel, pc, valid, output ready);

endinterface

//--- source/store_accept.sv
/* Input side of the store path. Aligns, strobes and checks pipeline stores,
   pushes legal ones into the store buffer and reports misaligned ones. */
`timescale 1ns/10ps

module store_accept
  import sbuf_pkg::*;
(
  input  logic            clk,
  input  logic            rst,
  input  logic            st_valid_i,
  output logic            st_ready_o,
  input  logic [XLEN-1:0] st_adr_i,
  input  logic [XLEN-1:0] st_dat_i,
  input  logic [XLEN-1:0] st_pc_i,
  input  store_size_e     st_size_i,
  output logic            misalign_o,
  output logic [XLEN-1:0] misalign_pc_o,
  store_entry_if.src      acc_o
);

  logic              misaligned; // Size and low address bits disagree.
  logic              accept;     // Pipeline handshake done this cycle.
  logic [STRB_W-1:0] strb;
  logic [XLEN-1:0]   wdat;

  // Lane selection and data replication per access size.
  always_comb begin
    misaligned = 1'b0;
    strb       = '1;
    wdat       = st_dat_i;
    case (st_size_i)
      SIZE_BYTE: begin
        strb = STRB_W'(1) << st_adr_i[1:0];     // One lane.
        wdat = {STRB_W{st_dat_i[7:0]}};
      end
      SIZE_HALF: begin
        misaligned = st_adr_i[0];
        strb       = STRB_W'(2'b11) << {st_adr_i[1], 1'b0}; // Low or high half.
        wdat       = {(STRB_W / 2){st_dat_i[15:0]}};
      end
      default: begin
        misaligned = |st_adr_i[1:0];            // Word must sit on a word boundary.
      end
    endcase
  end

  // Ready comes straight from the buffer, even for stores that will be dropped.
  assign st_ready_o = acc_o.ready;
  assign accept     = st_valid_i && st_ready_o;

  assign acc_o.valid = st_valid_i && !misaligned; // Only legal stores are offered.
  assign acc_o.adr   = {st_adr_i[XLEN-1:2], 2'b00};
  assign acc_o.dat   = wdat;
  assign acc_o.bsel  = strb;
  assign acc_o.pc    = st_pc_i;

  // Misalignment report, one cycle after acceptance.
  always_ff @(posedge clk) begin
    if (rst) begin
      misalign_o <= 1'b0;
    end else begin
      misalign_o <= accept && misaligned;
    end
  end

  always_ff @(posedge clk) begin
    if (accept && misaligned) begin
      misalign_pc_o <= st_pc_i; // Held until the next bad store.
    end
  end

endmodule

//--- source/store_fifo_ram.sv
/* Simple dual-port RAM on one clock with registered read.
   A write to the address being read is forwarded to the output. */
`timescale 1ns/10ps

module store_fifo_ram
  import sbuf_pkg::*;
#(
  parameter int ADDR_W = 2,
  parameter int DATA_W = XLEN
) (
  input  logic              clk,
  input  logic              we_i,
  input  logic [ADDR_W-1:0] waddr_i,
  input  logic [DATA_W-1:0] din_i,
  input  logic [ADDR_W-1:0] raddr_i,
  output logic [DATA_W-1:0] dout_o
);

  logic [DATA_W-1:0] mem [2**ADDR_W];

  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[waddr_i] <= din_i;
    end
  end

  // Read every cycle. Bypass so a fresh entry shows up on the next cycle.
  always_ff @(posedge clk) begin
    if (we_i && (waddr_i == raddr_i)) begin
      dout_o <= din_i;
    end else begin
      dout_o <= mem[raddr_i];
    end
  end

endmodule

//--- source/store_buffer.sv
/* Store buffer FIFO around a dual-port RAM with read-ahead.
   Entries pushed in one cycle are offered at the head in the next. */
`timescale 1ns/10ps

module store_buffer
  import sbuf_pkg::*;
#(
  parameter int DEPTH_W = 2
) (
  input  logic       clk,
  input  logic       rst,
  store_entry_if.dst in_i,
  store_entry_if.src out_o
);

  localparam int ENT_W = 3 * XLEN + STRB_W; // pc + adr + dat + bsel.
  localparam int DEPTH = 1 << DEPTH_W;

  logic [DEPTH_W:0] wr_ptr;     // Extra MSB tells full from empty.
  logic [DEPTH_W:0] rd_ptr;
  logic [DEPTH_W:0] rd_ptr_nxt;
  logic [DEPTH_W:0] occ;        // Entries held.
  logic             full;
  logic             empty;
  logic             push;
  logic             pop;
  logic [ENT_W-1:0] ram_din;
  logic [ENT_W-1:0] ram_dout;

  assign full  = (wr_ptr[DEPTH_W] != rd_ptr[DEPTH_W]) &&
                 (wr_ptr[DEPTH_W-1:0] == rd_ptr[DEPTH_W-1:0]);
  assign empty = (wr_ptr == rd_ptr);
  assign occ   = wr_ptr - rd_ptr;

  assign in_i.ready  = !full;
  assign out_o.valid = !empty;
  assign push        = in_i.valid && in_i.ready;
  assign pop         = out_o.valid && out_o.ready;

  // Look one entry ahead on a pop so the new head is out next cycle.
  assign rd_ptr_nxt = rd_ptr + (DEPTH_W + 1)'(pop);

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      rd_ptr <= rd_ptr_nxt;
    end
  end

  assign ram_din = {in_i.pc, in_i.adr, in_i.dat, in_i.bsel};
  assign {out_o.pc, out_o.adr, out_o.dat, out_o.bsel} = ram_dout;

  store_fifo_ram #(
    .ADDR_W (DEPTH_W),
    .DATA_W (ENT_W)
  ) u_ram (
    .clk     (clk),
    .we_i    (push),
    .waddr_i (wr_ptr[DEPTH_W-1:0]),
    .din_i   (ram_din),
    .raddr_i (rd_ptr_nxt[DEPTH_W-1:0]),
    .dout_o  (ram_dout)
  );

  // A push into a full buffer would drive the fill level past the depth.
  a_no_overflow: assert property (@(posedge clk) disable iff (rst) occ <= DEPTH)
    else $error("store buffer overflow");

  // The consumer may only take the head while an entry is offered.
  a_no_underflow: assert property (@(posedge clk) disable iff (rst)
    out_o.ready |-> !empty)
    else $error("store buffer underflow");

endmodule

//--- source/apb_store_master.sv
/* APB3 requester that drains the store buffer as write transfers.
   Slave errors are reported with the pc and address of the failing store. */
`timescale 1ns/10ps

module apb_store_master
  import sbuf_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  store_entry_if.dst        head_i,
  output logic [XLEN-1:0]   paddr_o,
  output logic [XLEN-1:0]   pwdata_o,
  output logic [STRB_W-1:0] pstrb_o,
  output logic              psel_o,
  output logic              penable_o,
  output logic              pwrite_o,
  input  logic              pready_i,
  input  logic              pslverr_i,
  output logic              buserr_o,
  output logic [XLEN-1:0]   buserr_pc_o,
  output logic [XLEN-1:0]   buserr_adr_o
);

  localparam logic [1:0] ST_IDLE   = 2'd0;
  localparam logic [1:0] ST_SETUP  = 2'd1;
  localparam logic [1:0] ST_ACCESS = 2'd2;

  logic [1:0]      state;
  logic [XLEN-1:0] ent_pc; // Pc of the store on the bus.
  logic            done;   // Access phase ends this cycle.

  assign done         = (state == ST_ACCESS) && pready_i;
  assign head_i.ready = done;                 // Pop only once the slave has it.

  assign psel_o    = (state != ST_IDLE);
  assign penable_o = (state == ST_ACCESS);
  assign pwrite_o  = psel_o;                  // Write-only requester.

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (head_i.valid) begin
            state <= ST_SETUP;
          end
        end
        ST_SETUP: begin
          state <= ST_ACCESS;                 // Setup is always one cycle.
        end
        ST_ACCESS: begin
          if (pready_i) begin
            state <= ST_IDLE; // Next head settles while idle.
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // Head entry is copied once and held through wait states.
  always_ff @(posedge clk) begin
    if ((state == ST_IDLE) && head_i.valid) begin
      paddr_o  <= head_i.adr;
      pwdata_o <= head_i.dat;
      pstrb_o  <= head_i.bsel;
      ent_pc   <= head_i.pc;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      buserr_o <= 1'b0;
    end else begin
      buserr_o <= done && pslverr_i;
    end
  end

  always_ff @(posedge clk) begin
    if (done && pslverr_i) begin
      buserr_pc_o  <= ent_pc;
      buserr_adr_o <= paddr_o;
    end
  end

  // Transfer fields must not move between setup and the end of access.
  a_apb_stable: assert property (@(posedge clk) disable iff (rst)
    psel_o && !(penable_o && pready_i) |=> $stable({paddr_o, pwdata_o, pstrb_o}))
    else $error("APB write fields changed during transfer");

endmodule

//--- source/store_unit_top.sv
/* Store path of the load/store unit, from pipeline stores to APB writes.
   Connects the input side, the store buffer and the APB requester. */
`timescale 1ns/10ps

module store_unit_top
  import sbuf_pkg::*;
#(
  parameter int DEPTH_W = 2 // Buffer holds 2**DEPTH_W stores.
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              st_valid_i,
  output logic              st_ready_o,
  input  logic [XLEN-1:0]   st_adr_i,
  input  logic [XLEN-1:0]   st_dat_i,
  input  logic [XLEN-1:0]   st_pc_i,
  input  store_size_e       st_size_i,
  output logic              misalign_o,
  output logic [XLEN-1:0]   misalign_pc_o,
  output logic [XLEN-1:0]   paddr_o,
  output logic [XLEN-1:0]   pwdata_o,
  output logic [STRB_W-1:0] pstrb_o,
  output logic              psel_o,
  output logic              penable_o,
  output logic              pwrite_o,
  input  logic              pready_i,
  input  logic              pslverr_i,
  output logic              buserr_o,
  output logic [XLEN-1:0]   buserr_pc_o,
  output logic [XLEN-1:0]   buserr_adr_o
);

  store_entry_if acc_if ();  // Legal stores into the buffer.
  store_entry_if head_if (); // Oldest buffered store.

  store_accept u_accept (
    .clk           (clk),
    .rst           (rst),
    .st_valid_i    (st_valid_i),
    .st_ready_o    (st_ready_o),
    .st_adr_i      (st_adr_i),
    .st_dat_i      (st_dat_i),
    .st_pc_i       (st_pc_i),
    .st_size_i     (st_size_i),
    .misalign_o    (misalign_o),
    .misalign_pc_o (misalign_pc_o),
    .acc_o         (acc_if.src)
  );

  store_buffer #(
    .DEPTH_W (DEPTH_W)
  ) u_buffer (
    .clk   (clk),
    .rst   (rst),
    .in_i  (acc_if.dst),
    .out_o (head_if.src)
  );

  apb_store_master u_apb (
    .clk          (clk),
    .rst          (rst),
    .head_i       (head_if.dst),
    .paddr_o      (paddr_o),
    .pwdata_o     (pwdata_o),
    .pstrb_o      (pstrb_o),
    .psel_o       (psel_o),
    .penable_o    (penable_o),
    .pwrite_o     (pwrite_o),
    .pready_i     (pready_i),
    .pslverr_i    (pslverr_i),
    .buserr_o     (buserr_o),
    .buserr_pc_o  (buserr_pc_o),
    .buserr_adr_o (buserr_adr_o)
  );

endmodule

//--- verif/tb_clock_gen.sv
/* Testbench clock and synchronous reset source for the store unit testbench. */
`timescale 1ns/10ps

module tb_clock_gen #(
  parameter int PERIOD     = 100, // Clock period in ns.
  parameter int RST_CYCLES = 3    // Rising edges seen with reset high.
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD / 2) clk_o = ~clk_o;
    end
  end

  initial begin
    rst_o = 1'b1;
    repeat (RST_CYCLES) @(posedge clk_o);
    #10 rst_o = 1'b0; // Released off the edge, like the other stimulus.
  end

endmodule

//--- verif/store_unit_tb.sv
/* Self-checking testbench for the store unit. Random stores go in, an APB slave
   model answers, and a reference queue predicts every write and report. */
`timescale 1ns/10ps

module store_unit_tb
  import sbuf_pkg::*;
();

  localparam int DEPTH_W    = 2;
  localparam int DEPTH      = 1 << DEPTH_W;
  localparam int NUM_STORES = 300;
  localparam int CLK_PERIOD = 100;
  localparam int ENT_W      = 3 * XLEN + STRB_W; // {pc, adr, dat, strb}.

  logic              clk;
  logic              rst;
  logic              st_valid_i;
  logic              st_ready_o;
  logic [XLEN-1:0]   st_adr_i;
  logic [XLEN-1:0]   st_dat_i;
  logic [XLEN-1:0]   st_pc_i;
  store_size_e       st_size_i;
  logic              misalign_o;
  logic [XLEN-1:0]   misalign_pc_o;
  logic [XLEN-1:0]   paddr_o;
  logic [XLEN-1:0]   pwdata_o;
  logic [STRB_W-1:0] pstrb_o;
  logic              psel_o;
  logic              penable_o;
  logic              pwrite_o;
  logic              pready_i;
  logic              pslverr_i;
  logic              buserr_o;
  logic [XLEN-1:0]   buserr_pc_o;
  logic [XLEN-1:0]   buserr_adr_o;

  logic [ENT_W-1:0]  exp_q[$];    // Legal stores not yet written on APB.
  int                outstanding; // Accepted legal stores not yet completed.
  int                sent;        // Stores taken by the DUT.
  logic              st_taken;    // Pipeline handshake seen this cycle.
  logic              exp_mis;     // Misalign pulse due this cycle.
  logic [XLEN-1:0]   exp_mis_pc;
  logic              exp_err;     // Bus error pulse due this cycle.
  logic [XLEN-1:0]   exp_err_pc;
  logic [XLEN-1:0]   exp_err_adr;
  logic              prev_psel;   // APB outputs of the previous cycle.
  logic              prev_penable;
  logic              prev_pready;
  logic [XLEN-1:0]   prev_paddr;
  logic [XLEN-1:0]   prev_pwdata;
  logic [STRB_W-1:0] prev_pstrb;
  int                wait_left;   // Slave wait states still to insert.
  logic              err_pick;    // Slave answers this transfer with an error.
  int                mismatch_cnt;
  int                fail_cnt;
  int                write_cnt;
  int                mis_cnt;
  int                err_cnt;
  integer            seed;

  tb_clock_gen #(.PERIOD(CLK_PERIOD), .RST_CYCLES(3)) i_clock_gen (.clk_o(clk), .rst_o(rst));

  store_unit_top #(.DEPTH_W(DEPTH_W)) i_store_unit_top (.*);

  task automatic report_mismatch(input string name, input logic [XLEN-1:0] got,
                                 input logic [XLEN-1:0] exp);
    $display("mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
    mismatch_cnt++;
  endtask

  task automatic report_failure(input string what);
    $display("%s at %0t", what, $time);
    fail_cnt++;
  endtask

  // Byte lanes written by one store.
  function automatic logic [STRB_W-1:0] lane_strobes(store_size_e sz, logic [1:0] lo);
    case (sz)
      SIZE_BYTE: return 4'b0001 << lo;
      SIZE_HALF: return lo[1] ? 4'b1100 : 4'b0011;
      default:   return 4'b1111;
    endcase
  endfunction

  function automatic logic [XLEN-1:0] lane_data(store_size_e sz, logic [XLEN-1:0] d);
    case (sz)
      SIZE_BYTE: return {4{d[7:0]}};  // Low byte on every lane.
      SIZE_HALF: return {2{d[15:0]}};
      default:   return d;
    endcase
  endfunction

  function automatic logic is_misaligned(store_size_e sz, logic [1:0] lo);
    return (sz == SIZE_HALF && lo[0]) || (sz == SIZE_WORD && lo != 2'b00);
  endfunction

  // Setup before access, fields held and pwrite_o high through the transfer.
  task automatic check_apb_protocol();
    logic in_xfer;
    in_xfer = prev_psel && !(prev_penable && prev_pready);
    if (psel_o && !pwrite_o) report_failure("pwrite_o low while psel_o is high");
    if (in_xfer) begin
      if (!(psel_o && penable_o)) report_failure("APB transfer dropped before pready_i");
      if (paddr_o !== prev_paddr) report_mismatch("paddr_o", paddr_o, prev_paddr);
      if (pwdata_o !== prev_pwdata) report_mismatch("pwdata_o", pwdata_o, prev_pwdata);
      if (pstrb_o !== prev_pstrb) report_mismatch("pstrb_o", pstrb_o, prev_pstrb);
    end else if (penable_o) begin
      report_failure("APB access phase without a setup cycle before it");
    end
  endtask

  // Runs mid-cycle, where inputs and outputs are settled.
  task automatic check_cycle();
    logic [ENT_W-1:0] ent;
    logic [XLEN-1:0]  ent_adr;
    logic             done;
    done = psel_o && penable_o && pready_i;
    if (st_ready_o !== (outstanding != DEPTH))
      report_mismatch("st_ready_o", st_ready_o, outstanding != DEPTH);
    if (misalign_o !== exp_mis) report_mismatch("misalign_o", misalign_o, exp_mis);
    else if (exp_mis && misalign_pc_o !== exp_mis_pc)
      report_mismatch("misalign_pc_o", misalign_pc_o, exp_mis_pc);
    if (buserr_o !== exp_err) report_mismatch("buserr_o", buserr_o, exp_err);
    else if (exp_err && buserr_pc_o !== exp_err_pc)
      report_mismatch("buserr_pc_o", buserr_pc_o, exp_err_pc);
    else if (exp_err && buserr_adr_o !== exp_err_adr)
      report_mismatch("buserr_adr_o", buserr_adr_o, exp_err_adr);
    check_apb_protocol();
    exp_err = 1'b0;
    if (done && exp_q.size() == 0) begin
      report_failure("APB write completed with no store waiting");
    end else if (done) begin
      ent     = exp_q.pop_front();                 // Oldest legal store.
      ent_adr = ent[STRB_W + XLEN +: XLEN];
      if (paddr_o !== ent_adr) report_mismatch("paddr_o", paddr_o, ent_adr);
      if (pwdata_o !== ent[STRB_W +: XLEN])
        report_mismatch("pwdata_o", pwdata_o, ent[STRB_W +: XLEN]);
      if (pstrb_o !== ent[STRB_W-1:0]) report_mismatch("pstrb_o", pstrb_o, ent[STRB_W-1:0]);
      exp_err     = pslverr_i;
      exp_err_pc  = ent[ENT_W-1 -: XLEN];
      exp_err_adr = ent_adr;
      err_cnt     += int'(pslverr_i);
      write_cnt++;
      outstanding--;
    end
    st_taken   = st_valid_i && st_ready_o;
    exp_mis    = st_taken && is_misaligned(st_size_i, st_adr_i[1:0]);
    exp_mis_pc = st_pc_i;
    if (exp_mis) begin
      mis_cnt++;                                   // Dropped, reported next cycle.
    end else if (st_taken) begin
      exp_q.push_back({st_pc_i, st_adr_i[XLEN-1:2], 2'b00, lane_data(st_size_i, st_dat_i),
                       lane_strobes(st_size_i, st_adr_i[1:0])});
      outstanding++;
    end
    prev_psel    = psel_o;
    prev_penable = penable_o;
    prev_pready  = pready_i;
    prev_paddr   = paddr_o;
    prev_pwdata  = pwdata_o;
    prev_pstrb   = pstrb_o;
  endtask

  // APB slave with 0 to 5 wait states and an error on about 1 in 8 transfers.
  task automatic respond_apb();
    if (psel_o && !penable_o) begin
      wait_left = $unsigned($random(seed)) % 6;
      err_pick  = ($unsigned($random(seed)) % 8) == 0;
      pready_i  = 1'b0;
      pslverr_i = 1'b0;
    end else if (psel_o && penable_o && wait_left == 0) begin
      pready_i  = 1'b1;
      pslverr_i = err_pick;
    end else begin
      if (psel_o) wait_left--;
      pready_i  = 1'b0;
      pslverr_i = 1'b0;
    end
  endtask

  task automatic drive_store();
    if (st_taken) sent++;
    if (st_valid_i && !st_taken) return;           // Hold the offered store.
    if (sent < NUM_STORES && ($random(seed) & 3) != 0) begin
      st_valid_i = 1'b1;
      st_adr_i   = $random(seed);
      st_dat_i   = $random(seed);
      st_pc_i    = $random(seed) & 32'hffff_fffc;
      st_size_i  = store_size_e'(2'($unsigned($random(seed)) % 3));
    end else begin
      st_valid_i = 1'b0;                           // Random gap.
    end
  endtask

  always @(negedge clk) begin
    if (!rst) check_cycle();
  end

  initial begin : main_seq
    seed = 32'h75e6;
    st_valid_i = 1'b0;
    st_adr_i = '0;
    st_dat_i = '0;
    st_pc_i = '0;
    st_size_i = SIZE_BYTE;
    pready_i = 1'b0;
    pslverr_i = 1'b0;
    {st_taken, exp_mis, exp_err, prev_psel, prev_penable, prev_pready, err_pick} = '0;
    {outstanding, sent, wait_left, mismatch_cnt, fail_cnt} = '0;
    {write_cnt, mis_cnt, err_cnt} = '0;
    wait (rst == 1'b0);
    #1;
    if (psel_o || penable_o || misalign_o || buserr_o || !st_ready_o)
      report_failure("outputs not in their reset state after reset");
    while (sent < NUM_STORES || outstanding != 0) begin
      @(posedge clk);
      #10;
      respond_apb();
      drive_store();
    end
    pready_i = 1'b0;
    repeat (3) @(posedge clk);                     // Let the last reports arrive.
    #10;
    if (psel_o) report_failure("APB transfer started after the last store completed");
    $display("end: %0d writes, %0d bus errors, %0d misaligned, %0d mismatch, %0d other",
             write_cnt, err_cnt, mis_cnt, mismatch_cnt, fail_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin : watchdog
    #(NUM_STORES * 12 * CLK_PERIOD);
    $display("timeout: %0d of %0d stores taken, %0d outstanding, %0d mismatch, %0d other",
             sent, NUM_STORES, outstanding, mismatch_cnt, fail_cnt);
    $display("Simulation failed");
    $finish;
  end

endmodule

//--- sources.f
source/sbuf_pkg.sv
source/store_entry_if.sv
source/store_accept.sv
source/store_fifo_ram.sv
source/store_buffer.sv
source/apb_store_master.sv
source/store_unit_top.sv
verif/tb_clock_gen.sv
verif/store_unit_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the store unit testbench with Verilator, runs it and checks for a pass.
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -sv -Wno-fatal -j 0 \
    --top-module store_unit_tb -Mdir obj_dir -f sources.f; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vstore_unit_tb)
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Simulation passed" <<< "$out"; then
  exit 0
fi
exit 1
